// File: sim.f
src/pwm_pkg.sv
src/axil_register_file.sv
src/pwm_control_unit.sv
src/pwm_timebase.sv
src/pwm_channel.sv
src/pwm_generator.sv
test/pwm_generator_properties.sv
test/pwm_generator_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the PWM generator testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module pwm_generator_tb \
    -o pwm_generator_sim > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/pwm_generator_sim > sim.log 2>&1 || echo "Simulator returned an error status"
grep -qF '** FAIL **' sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -qF '** PASS **' sim.log && echo "Simulation passed" || { echo "No result, see sim.log"; exit 1; }

// File: test/pwm_generator_tb.sv
/*
 * PWM generator testbench
 * Random register programming from a fixed seed, checked against a model of the
 * register map and of the PWM timing rules
 */
`timescale 1ns/1ps
`default_nettype none

module pwm_generator_tb;

    localparam int n_channels  = 4;
    localparam int n_registers = 1 + 2 * n_channels;
    // Twenty programmings with three windows of up to 1552 clocks each, plus bus traffic
    localparam int cycle_limit = 200000;

    logic                    clock;
    logic                    reset;
    logic                    external_tick;
    pwm_pkg::axil_request_t  request;
    pwm_pkg::axil_response_t response;
    logic [n_channels-1:0]   pwm_out;

    // Model copy of the register array that every bus write updates
    logic [31:0] model_regs [n_registers];
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          cycle_count;

    pwm_generator #(
        .n_channels(n_channels)
    ) dut0 (
        .clock(clock),
        .reset(reset),
        .request(request),
        .response(response),
        .external_tick(external_tick),
        .pwm_out(pwm_out)
    );

    // Xorshift32 generator
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int random_below(input int limit);
        return int'(next_random() % 32'(limit));
    endfunction

    function automatic int period_of(input int ch);
        return int'(model_regs[pwm_pkg::period_offset(ch)][pwm_pkg::counter_w-1:0]);
    endfunction

    function automatic int compare_of(input int ch);
        return int'(model_regs[pwm_pkg::compare_offset(ch)][pwm_pkg::counter_w-1:0]);
    endfunction

    // Control word assembled from the field positions of the register map
    function automatic logic [31:0] make_control(input int div, input logic enable,
            input logic external, input logic run, input logic sync_set,
            input logic [n_channels-1:0] stop);
        logic [31:0] word;
        word = '0;
        word[pwm_pkg::tb_div_lsb +: pwm_pkg::tb_div_w] = pwm_pkg::timebase_setting_t'(div);
        word[pwm_pkg::tb_en_bit]       = enable;
        word[pwm_pkg::tb_ext_en_bit]   = external;
        word[pwm_pkg::counter_run_bit] = run;
        word[pwm_pkg::sync_bit]        = sync_set;
        word[pwm_pkg::stop_state_lsb +: n_channels] = stop;
        return word;
    endfunction

    // Inputs change and outputs are read 1 ns after the rising edge
    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic wait_cycles(input int count);
        repeat (count) step();
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s expected 0x%h actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic report_problem(input string text);
        errors++;
        $display("%s", text);
    endtask

    // Address and data go out together and the write lands on the edge after ready
    task automatic bus_write(input int index, input logic [31:0] data);
        int stall;
        stall            = random_below(3);
        request.aw_addr  = 32'(index * 4);
        request.w_data   = data;
        request.aw_valid = 1'b1;
        request.w_valid  = 1'b1;
        request.b_ready  = 1'b0;
        step();
        while (!response.aw_ready) begin
            step();
        end
        compare_value("w_ready", 32'h1, 32'(response.w_ready));
        step();
        request.aw_valid = 1'b0;
        request.w_valid  = 1'b0;
        while (!response.b_valid) begin
            step();
        end
        // The response is held back for a few cycles and must stay valid
        wait_cycles(stall);
        compare_value("b_valid", 32'h1, 32'(response.b_valid));
        compare_value("b_resp", 32'h0, 32'(response.b_resp));
        request.b_ready = 1'b1;
        step();
        if (index < n_registers) begin
            model_regs[index] = data;
        end
    endtask

    task automatic bus_read(input int index, output logic [31:0] data);
        int stall;
        stall            = random_below(3);
        request.ar_addr  = 32'(index * 4);
        request.ar_valid = 1'b1;
        request.r_ready  = 1'b0;
        step();
        while (!response.ar_ready) begin
            step();
        end
        step();
        request.ar_valid = 1'b0;
        while (!response.r_valid) begin
            step();
        end
        // Read data waits for r_ready and must hold meanwhile
        wait_cycles(stall);
        compare_value("r_valid", 32'h1, 32'(response.r_valid));
        compare_value("r_resp", 32'h0, 32'(response.r_resp));
        data = response.r_data;
        request.r_ready = 1'b1;
        step();
    endtask

    task automatic pulse_external_tick();
        external_tick = 1'b1;
        step();
        external_tick = 1'b0;
        wait_cycles(3);
    endtask

    // Watches all outputs over three of the longest periods, then checks the spacing
    // of the last two rising edges and the last complete high pulse
    task automatic measure_channels(input int div);
        int rises [n_channels];
        int last_rise [n_channels];
        int spacing [n_channels];
        int high_time [n_channels];
        logic [n_channels-1:0] previous;
        int scale;
        int high_ticks;
        scale = 1 << div;
        for (int ch = 0; ch < n_channels; ch++) begin
            rises[ch]     = 0;
            last_rise[ch] = 0;
            spacing[ch]   = 0;
            high_time[ch] = 0;
        end
        previous = pwm_out;
        for (int t = 0; t < 3 * 64 * scale + 16; t++) begin
            step();
            for (int ch = 0; ch < n_channels; ch++) begin
                if (pwm_out[ch] && !previous[ch]) begin
                    spacing[ch]   = t - last_rise[ch];
                    last_rise[ch] = t;
                    rises[ch]++;
                end else if (!pwm_out[ch] && previous[ch]) begin
                    high_time[ch] = t - last_rise[ch];
                end
            end
            previous = pwm_out;
        end
        for (int ch = 0; ch < n_channels; ch++) begin
            // High for min(compare, period+1) ticks of every period+1
            high_ticks = compare_of(ch) < period_of(ch) + 1 ? compare_of(ch) : period_of(ch) + 1;
            if (high_ticks == 0 || high_ticks == period_of(ch) + 1) begin
                // The output stays low for compare 0 and high when compare covers the period
                compare_value($sformatf("pwm_out[%0d]", ch), 32'(high_ticks != 0),
                              32'(pwm_out[ch]));
                if (rises[ch] > 1) begin
                    report_problem($sformatf("Channel %0d toggled although constant", ch));
                end
            end else if (rises[ch] < 3) begin
                report_problem($sformatf("Channel %0d made too few rising edges", ch));
            end else begin
                compare_value($sformatf("pwm_out[%0d] period clocks", ch),
                              32'((period_of(ch) + 1) * scale), 32'(spacing[ch]));
                compare_value($sformatf("pwm_out[%0d] high clocks", ch),
                              32'(high_ticks * scale), 32'(high_time[ch]));
            end
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout, the tests did not finish within %0d cycles", cycle_limit);
        $display("** FAIL **");
        $finish;
    end

    initial begin : stimulus
        int period;
        int div;
        int new_div;
        int past_end;
        int first_rise [n_channels];
        logic [n_channels-1:0] previous;
        logic [31:0] word;
        logic [31:0] read_value;

        reset           = 1'b0;
        request         = '0;
        request.b_ready = 1'b1;
        request.r_ready = 1'b1;
        external_tick   = 1'b0;
        rng_state       = 32'd38694;
        errors          = 0;
        checks          = 0;
        for (int i = 0; i < n_registers; i++) begin
            model_regs[i] = '0;
        end
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b1;
        compare_value("pwm_out", 32'h0, 32'(pwm_out));
        compare_value("b_valid", 32'h0, 32'(response.b_valid));
        compare_value("r_valid", 32'h0, 32'(response.r_valid));

        // Read back every register and then an index past the end of the map
        for (int i = 0; i < n_registers; i++) begin
            bus_write(i, next_random());
        end
        past_end = n_registers + random_below(64 - n_registers);
        bus_write(past_end, next_random());
        for (int i = 0; i < n_registers; i++) begin
            bus_read(i, read_value);
            compare_value($sformatf("register %0d", i), model_regs[i], read_value);
        end
        bus_read(past_end, read_value);
        compare_value($sformatf("register %0d", past_end), 32'h0, read_value);

        // Stopped counters show the stop_state field
        for (int i = 0; i < 8; i++) begin
            word = next_random();
            word[pwm_pkg::counter_run_bit] = 1'b0;
            word[pwm_pkg::sync_bit]        = 1'b0;
            bus_write(pwm_pkg::ctrl_offset, word);
            wait_cycles(4);
            compare_value("pwm_out", 32'(word[pwm_pkg::stop_state_lsb +: n_channels]),
                          32'(pwm_out));
        end

        // Duty and period checks followed by a divisor change while running and after a restart
        for (int run = 0; run < 20; run++) begin
            bus_write(pwm_pkg::ctrl_offset, 32'h0);
            wait_cycles(4);
            for (int ch = 0; ch < n_channels; ch++) begin
                period = 1 + random_below(63);
                bus_write(pwm_pkg::period_offset(ch), 32'(period));
                bus_write(pwm_pkg::compare_offset(ch), 32'(random_below(period + 2)));
            end
            div = random_below(4);
            bus_write(pwm_pkg::ctrl_offset, make_control(div, 1'b1, 1'b0, 1'b1, 1'b0, '0));
            measure_channels(div);
            new_div = (div + 1 + random_below(3)) % 4;
            bus_write(pwm_pkg::ctrl_offset, make_control(new_div, 1'b1, 1'b0, 1'b1, 1'b0, '0));
            measure_channels(div);
            bus_write(pwm_pkg::ctrl_offset, make_control(new_div, 1'b1, 1'b0, 1'b0, 1'b0, '0));
            wait_cycles(4);
            bus_write(pwm_pkg::ctrl_offset, make_control(new_div, 1'b1, 1'b0, 1'b1, 1'b0, '0));
            measure_channels(new_div);
        end

        // The channels first drift apart on different periods and then share one for the sync
        bus_write(pwm_pkg::ctrl_offset, 32'h0);
        wait_cycles(4);
        period = 8 + random_below(40);
        for (int ch = 0; ch < n_channels; ch++) begin
            bus_write(pwm_pkg::period_offset(ch), 32'(4 + random_below(60)));
            bus_write(pwm_pkg::compare_offset(ch), 32'(1 + random_below(period)));
        end
        bus_write(pwm_pkg::ctrl_offset, make_control(0, 1'b1, 1'b0, 1'b1, 1'b0, '0));
        wait_cycles(50 + random_below(200));
        for (int ch = 0; ch < n_channels; ch++) begin
            bus_write(pwm_pkg::period_offset(ch), 32'(period));
        end
        bus_write(pwm_pkg::ctrl_offset, make_control(0, 1'b1, 1'b0, 1'b1, 1'b1, '0));
        // Skip the rises caused by the reload itself
        wait_cycles(4);
        previous = pwm_out;
        for (int ch = 0; ch < n_channels; ch++) begin
            first_rise[ch] = -1;
        end
        for (int t = 0; t < 2 * (period + 1) + 8; t++) begin
            step();
            for (int ch = 0; ch < n_channels; ch++) begin
                if (pwm_out[ch] && !previous[ch] && first_rise[ch] < 0) begin
                    first_rise[ch] = t;
                end
            end
            previous = pwm_out;
        end
        for (int ch = 0; ch < n_channels; ch++) begin
            if (first_rise[ch] < 0) begin
                report_problem($sformatf("Channel %0d did not rise after sync", ch));
            end else if (ch > 0) begin
                compare_value($sformatf("pwm_out[%0d] rise cycle", ch), 32'(first_rise[0]),
                              32'(first_rise[ch]));
            end
        end

        // The external timebase moves each counter one step per external tick pulse
        bus_write(pwm_pkg::ctrl_offset, 32'h0);
        wait_cycles(4);
        for (int ch = 0; ch < n_channels; ch++) begin
            period = 1 + random_below(15);
            bus_write(pwm_pkg::period_offset(ch), 32'(period));
            bus_write(pwm_pkg::compare_offset(ch), 32'(1 + random_below(period)));
        end
        bus_write(pwm_pkg::ctrl_offset, make_control(0, 1'b1, 1'b1, 1'b1, 1'b0, '0));
        for (int n = 0; n <= 32; n++) begin
            if (n == 0) begin
                wait_cycles(40);
            end else begin
                pulse_external_tick();
            end
            for (int ch = 0; ch < n_channels; ch++) begin
                compare_value($sformatf("pwm_out[%0d] after %0d ticks", ch, n),
                              32'((n % (period_of(ch) + 1)) < compare_of(ch)),
                              32'(pwm_out[ch]));
            end
        end

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/pwm_generator_properties.sv
/*
 * PWM generator properties
 * AXI-lite response handshake and sync pulse checks, bound into the generator
 */
`timescale 1ns/1ps
`default_nettype none

module pwm_generator_properties (
    input logic                    clock,
    input logic                    reset,
    input pwm_pkg::axil_request_t  request,
    input pwm_pkg::axil_response_t response,
    input logic                    sync
);

    // The write response stays up until the master takes it
    write_response_held : assert property (
        @(posedge clock) disable iff (!reset)
        response.b_valid && !request.b_ready |=> response.b_valid
    ) else $error("Write response dropped before b_ready");

    // Sync reloads the counters for exactly one cycle
    sync_single_pulse : assert property (
        @(posedge clock) disable iff (!reset)
        sync |=> !sync
    ) else $error("Sync pulse longer than one cycle");

    // Read data only follows an accepted read address
    read_after_address : assert property (
        @(posedge clock) disable iff (!reset)
        $rose(response.r_valid) |-> $past(response.ar_ready && request.ar_valid)
    ) else $error("Read data valid without an accepted read address");

endmodule

bind pwm_generator pwm_generator_properties properties0 (
    .clock(clock),
    .reset(reset),
    .request(request),
    .response(response),
    .sync(sync)
);

`default_nettype wire

// File: src/pwm_generator.sv
/*
 * Multi-channel PWM generator
 * Register file, control unit, timebase and one counter per channel
 */
`timescale 1ns/1ps
`default_nettype none

module pwm_generator #(
    parameter int n_channels = 4,
    parameter logic [pwm_pkg::max_channels-1:0] initial_stopped_state = '0
) (
    input  logic                    clock,
    input  logic                    reset,
    input  pwm_pkg::axil_request_t  request,
    output pwm_pkg::axil_response_t response,
    input  logic                    external_tick,
    output logic [n_channels-1:0]   pwm_out
);

    // Control word plus a period and a compare word per channel
    localparam int n_registers = 1 + 2 * n_channels;

    logic [n_registers*32-1:0]  registers;
    logic [31:0]                control_word;
    logic [n_channels-1:0]      counter_status;
    logic [n_channels-1:0]      counter_stopped_state;
    pwm_pkg::timebase_setting_t timebase_setting;
    logic                       timebase_enable;
    logic                       timebase_external_enable;
    logic                       counter_run;
    logic                       sync;
    logic                       tick;

    assign control_word = registers[pwm_pkg::ctrl_offset*32 +: 32];

    axil_register_file #(
        .n_registers(n_registers)
    ) register_file0 (
        .clock(clock),
        .reset(reset),
        .request(request),
        .response(response),
        .registers(registers)
    );

    pwm_control_unit #(
        .n_channels(n_channels),
        .initial_stopped_state(initial_stopped_state)
    ) control_unit0 (
        .clock(clock),
        .reset(reset),
        .control_word(control_word),
        .counter_status(counter_status),
        .timebase_setting(timebase_setting),
        .timebase_enable(timebase_enable),
        .timebase_external_enable(timebase_external_enable),
        .counter_run(counter_run),
        .sync(sync),
        .counter_stopped_state(counter_stopped_state)
    );

    pwm_timebase timebase0 (
        .clock(clock),
        .reset(reset),
        .timebase_setting(timebase_setting),
        .timebase_enable(timebase_enable),
        .timebase_external_enable(timebase_external_enable),
        .external_tick(external_tick),
        .tick(tick)
    );

    // Every channel shares tick, run and sync, with its own period and compare words
    for (genvar i = 0; i < n_channels; i++) begin : channel_gen
        pwm_channel channel0 (
            .clock(clock),
            .reset(reset),
            .tick(tick),
            .counter_run(counter_run),
            .sync(sync),
            .stopped_state(counter_stopped_state[i]),
            .period(registers[pwm_pkg::period_offset(i)*32 +: pwm_pkg::counter_w]),
            .compare(registers[pwm_pkg::compare_offset(i)*32 +: pwm_pkg::counter_w]),
            .busy(counter_status[i]),
            .pwm_out(pwm_out[i])
        );
    end

endmodule

`default_nettype wire

// File: src/pwm_channel.sv
/*
 * PWM channel
 * Period counter with compare output, sync reload and stopped-state output
 */
`timescale 1ns/1ps
`default_nettype none

module pwm_channel (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          tick,
    input  logic                          counter_run,
    input  logic                          sync,
    input  logic                          stopped_state,
    input  logic [pwm_pkg::counter_w-1:0] period,
    input  logic [pwm_pkg::counter_w-1:0] compare,
    output logic                          busy,
    output logic                          pwm_out
);

    logic [pwm_pkg::counter_w-1:0] counter;
    logic                          counter_wrap;
    logic                          compare_match;

    // Greater or equal so a shortened period still wraps at once
    assign counter_wrap  = counter >= period;
    assign compare_match = counter < compare;

    // Counter runs from 0 to period, one step per tick
    always_ff @(posedge clock) begin
        if (!reset) begin
            counter <= '0;
            busy    <= 1'b0;
        end else begin
            busy <= counter_run;
            if (!counter_run || sync) begin
                counter <= '0;
            end else if (tick) begin
                if (counter_wrap) begin
                    counter <= '0;
                end else begin
                    counter <= counter + 1'b1;
                end
            end
        end
    end

    // Output is high for compare counts of every period+1
    // While stopped it follows the stopped state, which the control unit resets
    always_ff @(posedge clock) begin
        if (counter_run) begin
            pwm_out <= compare_match;
        end else begin
            pwm_out <= stopped_state;
        end
    end

endmodule

`default_nettype wire

// File: src/pwm_timebase.sv
/*
 * PWM timebase
 * One-cycle tick every 2**setting clocks, or one tick per external tick edge
 */
`timescale 1ns/1ps
`default_nettype none

module pwm_timebase (
    input  logic                       clock,
    input  logic                       reset,
    input  pwm_pkg::timebase_setting_t timebase_setting,
    input  logic                       timebase_enable,
    input  logic                       timebase_external_enable,
    input  logic                       external_tick,
    output logic                       tick
);

    // Wide enough for the largest divisor exponent
    localparam int prescaler_w = 2**$bits(pwm_pkg::timebase_setting_t) - 1;

    logic [prescaler_w-1:0] prescaler;
    logic [prescaler_w-1:0] wrap_mask;
    logic                   external_tick_q;
    logic                   internal_tick;
    logic                   external_rise;

    // Low setting bits of the prescaler, all ones just before they wrap
    assign wrap_mask     = ~({prescaler_w{1'b1}} << timebase_setting);
    assign internal_tick = (prescaler & wrap_mask) == wrap_mask;
    assign external_rise = external_tick && !external_tick_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            prescaler       <= '0;
            external_tick_q <= 1'b0;
            tick            <= 1'b0;
        end else begin
            external_tick_q <= external_tick;

            // Prescaler restarts from zero whenever the internal timebase is off
            if (timebase_enable && !timebase_external_enable) begin
                prescaler <= prescaler + 1'b1;
            end else begin
                prescaler <= '0;
            end

            if (!timebase_enable) begin
                tick <= 1'b0;
            end else if (timebase_external_enable) begin
                tick <= external_rise;
            end else begin
                tick <= internal_tick;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pwm_control_unit.sv
/*
 * PWM control unit
 * Decodes the control word into timebase settings, run, sync pulse and stopped state
 */
`timescale 1ns/1ps
`default_nettype none

module pwm_control_unit #(
    parameter int n_channels = 4,
    parameter logic [pwm_pkg::max_channels-1:0] initial_stopped_state = '0
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [31:0]                control_word,
    input  logic [n_channels-1:0]      counter_status,
    output pwm_pkg::timebase_setting_t timebase_setting,
    output logic                       timebase_enable,
    output logic                       timebase_external_enable,
    output logic                       counter_run,
    output logic                       sync,
    output logic [n_channels-1:0]      counter_stopped_state
);

    // Set after a sync pulse until software clears the sync bit
    logic sync_wait;
    logic sync_request;
    logic counters_idle;

    assign sync_request  = control_word[pwm_pkg::sync_bit];
    assign counters_idle = ~|counter_status;

    // Sync produces one pulse per rising of the bit
    always_ff @(posedge clock) begin
        if (!reset) begin
            sync      <= 1'b0;
            sync_wait <= 1'b0;
        end else begin
            if (!sync_wait && sync_request) begin
                sync      <= 1'b1;
                sync_wait <= 1'b1;
            end else begin
                sync <= 1'b0;
                // Rearm once the bit has been cleared
                if (!sync_request) begin
                    sync_wait <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            timebase_setting         <= '0;
            timebase_enable          <= 1'b0;
            timebase_external_enable <= 1'b0;
            counter_run              <= 1'b0;
            counter_stopped_state    <= initial_stopped_state[n_channels-1:0];
        end else begin
            // The tick rate is only changed while no counter is in a period
            if (counters_idle) begin
                timebase_setting         <= control_word[pwm_pkg::tb_div_lsb +: pwm_pkg::tb_div_w];
                timebase_enable          <= control_word[pwm_pkg::tb_en_bit];
                timebase_external_enable <= control_word[pwm_pkg::tb_ext_en_bit];
            end
            counter_run           <= control_word[pwm_pkg::counter_run_bit];
            counter_stopped_state <= control_word[pwm_pkg::stop_state_lsb +: n_channels];
        end
    end

endmodule

`default_nettype wire

// File: src/axil_register_file.sv
/*
 * AXI-lite register file
 * Holds n_registers read-write words and exposes them as one flat vector
 */
`timescale 1ns/1ps
`default_nettype none

module axil_register_file #(
    parameter int n_registers = 9
) (
    input  logic                       clock,
    input  logic                       reset,
    input  pwm_pkg::axil_request_t     request,
    output pwm_pkg::axil_response_t    response,
    output logic [n_registers*32-1:0]  registers
);

    // Word index taken from the masked byte address
    localparam int index_w = pwm_pkg::axil_addr_w - 2;
    localparam logic [pwm_pkg::axil_addr_w-1:0] address_mask = {{index_w{1'b1}}, 2'b00};

    logic [index_w-1:0] write_index;
    logic [index_w-1:0] read_index;
    logic               write_ready;
    logic               write_response_valid;
    logic               read_ready;
    logic               read_valid;
    logic [31:0]        read_data;
    logic               write_start;
    logic               write_fire;
    logic               read_start;
    logic               read_fire;

    function automatic logic [index_w-1:0] word_index(input logic [31:0] address);
        logic [pwm_pkg::axil_addr_w-1:0] masked;
        masked = address[pwm_pkg::axil_addr_w-1:0] & address_mask;
        return masked[pwm_pkg::axil_addr_w-1:2];
    endfunction

    assign write_index = word_index(request.aw_addr);
    assign read_index  = word_index(request.ar_addr);

    // A write starts only with address and data both present and no response pending
    assign write_start = request.aw_valid && request.w_valid
                         && !write_ready && !write_response_valid;
    assign write_fire  = write_ready && request.aw_valid && request.w_valid;

    // Reads wait for the previous read data to be taken
    assign read_start = request.ar_valid && !read_ready && !read_valid;
    assign read_fire  = read_ready && request.ar_valid;

    // Handshake state, ready pulses for a single cycle
    always_ff @(posedge clock) begin
        if (!reset) begin
            write_ready          <= 1'b0;
            write_response_valid <= 1'b0;
            read_ready           <= 1'b0;
            read_valid           <= 1'b0;
        end else begin
            write_ready <= write_start;
            read_ready  <= read_start;

            // The write response holds until the master takes it
            if (write_fire) begin
                write_response_valid <= 1'b1;
            end else if (request.b_ready) begin
                write_response_valid <= 1'b0;
            end

            if (read_fire) begin
                read_valid <= 1'b1;
            end else if (request.r_ready) begin
                read_valid <= 1'b0;
            end
        end
    end

    // Register storage, indexes past the end are dropped
    always_ff @(posedge clock) begin
        if (!reset) begin
            registers <= '0;
        end else if (write_fire && int'(write_index) < n_registers) begin
            registers[write_index*32 +: 32] <= request.w_data;
        end
    end

    // Read data is captured with the address and holds while r_valid waits
    always_ff @(posedge clock) begin
        if (read_fire) begin
            if (int'(read_index) < n_registers) begin
                read_data <= registers[read_index*32 +: 32];
            end else begin
                read_data <= '0;
            end
        end
    end

    assign response = '{
        aw_ready: write_ready,
        w_ready:  write_ready,
        b_valid:  write_response_valid,
        b_resp:   pwm_pkg::axil_resp_okay,
        ar_ready: read_ready,
        r_valid:  read_valid,
        r_data:   read_data,
        r_resp:   pwm_pkg::axil_resp_okay
    };

endmodule

`default_nettype wire

// File: src/pwm_pkg.sv
/*
 * PWM generator package
 * AXI-lite request and response structs, register map and control-field positions
 */
`default_nettype none

package pwm_pkg;

    // Bus widths, only the low address bits take part in decoding
    localparam int axil_addr_w = 8;
    localparam int axil_data_w = 32;

    // Response code for a normal access, the only one this slave returns
    localparam logic [1:0] axil_resp_okay = 2'b00;

    // Master to slave signals of the AXI-lite bus
    typedef struct packed {
        logic                   aw_valid;
        logic [axil_data_w-1:0] aw_addr;
        logic                   w_valid;
        logic [axil_data_w-1:0] w_data;
        logic                   b_ready;
        logic                   ar_valid;
        logic [axil_data_w-1:0] ar_addr;
        logic                   r_ready;
    } axil_request_t;

    // Slave to master signals of the AXI-lite bus
    typedef struct packed {
        logic                   aw_ready;
        logic                   w_ready;
        logic                   b_valid;
        logic [1:0]             b_resp;
        logic                   ar_ready;
        logic                   r_valid;
        logic [axil_data_w-1:0] r_data;
        logic [1:0]             r_resp;
    } axil_response_t;

    // Divisor exponent of the timebase, the tick comes every 2**n clocks
    typedef logic [2:0] timebase_setting_t;

    // Width of the channel counters and of the used part of period and compare
    localparam int counter_w = 16;

    // Largest channel count that fits the stop_state field
    localparam int max_channels = 16;

    // Register indexes, the control word comes first
    localparam int ctrl_offset = 0;

    // Each channel owns a period word followed by a compare word
    function automatic int period_offset(input int channel);
        return 1 + 2 * channel;
    endfunction

    function automatic int compare_offset(input int channel);
        return 2 + 2 * channel;
    endfunction

    // Fields of the control word
    localparam int tb_div_lsb      = 0;
    localparam int tb_div_w        = $bits(timebase_setting_t);
    localparam int tb_en_bit       = 3;
    localparam int tb_ext_en_bit   = 4;
    localparam int counter_run_bit = 5;
    localparam int sync_bit        = 6;
    localparam int stop_state_lsb  = 7;

endpackage

`default_nettype wire
